/* disp_pkg.sv */
`default_nettype none

package disp_pkg;

    localparam int DATA_W = 8;
    localparam int GAP_W = 8;
    localparam int REP_W = 8;

    localparam int SCRIPT_LEN = 40;
    localparam int IDX_W = $clog2(SCRIPT_LEN);

    // Upper byte of each bus word
    localparam logic [7:0] FLAG_CMD = 8'h80;
    localparam logic [7:0] FLAG_DATA = 8'h00;
    localparam logic [7:0] FLAG_READ = 8'h40;

    typedef enum logic [1:0] {
        cmd_write   = 2'd0,
        data_write  = 2'd1,
        status_poll = 2'd2
    } entry_kind_t;

    // For a poll, value is the polled register and count the pair count
    typedef struct packed {
        entry_kind_t       kind;
        logic [DATA_W-1:0] value;
        logic [GAP_W-1:0]  gap;
        logic [REP_W-1:0]  count;
    } script_entry_t;

    typedef struct packed {
        entry_kind_t       kind;
        logic [DATA_W-1:0] value;
    } word_desc_t;

    typedef struct packed {
        logic [7:0]        flags;
        logic [DATA_W-1:0] data;
    } bus_word_t;

endpackage

`default_nettype wire

/* script_rom.sv */
`timescale 1ns/1ns
`default_nettype none

module script_rom
    import disp_pkg::*;
(
    input  logic             clk,
    input  logic             nrst,
    input  logic [IDX_W-1:0] rd_idx,
    output script_entry_t    rd_entry
);

    script_entry_t entry;

    function automatic script_entry_t cmd(logic [DATA_W-1:0] reg_num, logic [GAP_W-1:0] gap);
        cmd = '{cmd_write, reg_num, gap, REP_W'(1)};
    endfunction

    function automatic script_entry_t dat(logic [DATA_W-1:0] val, logic [GAP_W-1:0] gap);
        dat = '{data_write, val, gap, REP_W'(1)};
    endfunction

    function automatic script_entry_t poll(logic [DATA_W-1:0] reg_num, logic [REP_W-1:0] pairs,
                                           logic [GAP_W-1:0] gap);
        poll = '{status_poll, reg_num, gap, pairs};
    endfunction

    always_comb begin
        case (rd_idx)
            // Soft reset, then status
            0:  entry = poll(8'h00, 8'd1, 8'd1);
            // PLL setup needs time to lock
            1:  entry = cmd(8'h88, 8'd1);
            2:  entry = dat(8'h0B, 8'd43);
            3:  entry = cmd(8'h89, 8'd1);
            4:  entry = dat(8'h02, 8'd43);
            5:  entry = cmd(8'h10, 8'd1);
            6:  entry = dat(8'h0C, 8'd1);
            7:  entry = cmd(8'h04, 8'd1);
            8:  entry = dat(8'h81, 8'd43);
            // Panel timing
            9:  entry = cmd(8'h14, 8'd1);
            10: entry = dat(8'h63, 8'd1);
            11: entry = cmd(8'h19, 8'd1);
            12: entry = dat(8'hDF, 8'd4);
            // Window and colour
            13: entry = cmd(8'h36, 8'd1);
            14: entry = dat(8'hDF, 8'd1);
            15: entry = cmd(8'h8A, 8'd1);
            16: entry = dat(8'h8A, 8'd1);
            17: entry = cmd(8'h90, 8'd1);
            18: entry = dat(8'hB0, 8'd1);
            19: entry = poll(8'h90, 8'd60, 8'd1);
            20: entry = poll(8'h40, 8'd1, 8'd1);
            // Area fill
            21: entry = cmd(8'h99, 8'd1);
            22: entry = dat(8'h90, 8'd1);
            23: entry = cmd(8'h9A, 8'd1);
            24: entry = dat(8'h01, 8'd1);
            25: entry = cmd(8'h9B, 8'd1);
            26: entry = dat(8'hF0, 8'd1);
            27: entry = cmd(8'h9C, 8'd1);
            28: entry = dat(8'h00, 8'd1);
            29: entry = cmd(8'h9D, 8'd1);
            30: entry = dat(8'h32, 8'd1);
            31: entry = cmd(8'h63, 8'd1);
            32: entry = dat(8'h1F, 8'd1);
            33: entry = cmd(8'h64, 8'd1);
            34: entry = dat(8'h00, 8'd1);
            35: entry = cmd(8'h65, 8'd1);
            36: entry = dat(8'h1F, 8'd1);
            37: entry = cmd(8'h90, 8'd1);
            38: entry = dat(8'h60, 8'd1);
            39: entry = poll(8'h90, 8'd60, 8'd1);
            default: entry = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            rd_entry <= '0;
        end else begin
            rd_entry <= entry;
        end
    end

endmodule

`default_nettype wire

/* step_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module step_sequencer
    import disp_pkg::*;
#(
    parameter int GAP_UNIT = 3
) (
    input  logic             clk,
    input  logic             nrst,
    output logic [IDX_W-1:0] rd_idx,
    input  script_entry_t    rd_entry,
    output word_desc_t       desc,
    output logic             desc_valid,
    input  logic             desc_ready,
    input  logic             word_taken,
    output logic             done
);

    localparam int CNT_W = GAP_W + $clog2(GAP_UNIT + 1);
    localparam logic [CNT_W-1:0] UNIT = CNT_W'(GAP_UNIT);

    typedef enum logic [1:0] {
        st_fetch,
        st_emit,
        st_wait_gap,
        st_finished
    } state_t;

    state_t           state;
    logic [IDX_W-1:0] idx;
    logic [REP_W-1:0] rep;
    logic             phase;
    logic             counting;
    logic [CNT_W-1:0] gap_cnt;
    logic             is_poll;
    logic             last_word;

    assign is_poll = (rd_entry.kind == status_poll);
    // Read half of the final pair ends a poll entry
    assign last_word = !is_poll || (phase && (rep + 1'b1 >= rd_entry.count));

    assign rd_idx = idx;
    assign desc_valid = (state == st_emit);
    assign done = (state == st_finished);

    always_comb begin
        desc.value = rd_entry.value;
        desc.kind = rd_entry.kind;
        if (is_poll && !phase) begin
            desc.kind = cmd_write;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state <= st_fetch;
            idx <= '0;
            rep <= '0;
            phase <= 1'b0;
            counting <= 1'b0;
            gap_cnt <= '0;
        end else begin
            case (state)
                // ROM output is valid one cycle after the index
                st_fetch: begin
                    state <= st_emit;
                end
                st_emit: begin
                    if (desc_ready) begin
                        state <= st_wait_gap;
                        counting <= 1'b0;
                    end
                end
                st_wait_gap: begin
                    if (!counting) begin
                        if (word_taken) begin
                            counting <= 1'b1;
                            gap_cnt <= CNT_W'(rd_entry.gap) * UNIT;
                        end
                    end else if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end else if (!last_word) begin
                        phase <= !phase;
                        if (phase) begin
                            rep <= rep + 1'b1;
                        end
                        state <= st_emit;
                    end else if (idx == IDX_W'(SCRIPT_LEN - 1)) begin
                        state <= st_finished;
                    end else begin
                        idx <= idx + 1'b1;
                        rep <= '0;
                        phase <= 1'b0;
                        state <= st_fetch;
                    end
                end
                default: begin
                    state <= st_finished;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* bus_out_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_out_stage
    import disp_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  word_desc_t desc,
    input  logic       desc_valid,
    output logic       desc_ready,
    output bus_word_t  word,
    output logic       word_valid,
    input  logic       word_ready
);

    bus_word_t enc;

    always_comb begin
        enc.data = desc.value;
        case (desc.kind)
            cmd_write:  enc.flags = FLAG_CMD;
            data_write: enc.flags = FLAG_DATA;
            // Status read carries no data
            default: begin
                enc.flags = FLAG_READ;
                enc.data = '0;
            end
        endcase
    end

    // Empty, or emptied by this cycle's acceptance
    assign desc_ready = !word_valid || word_ready;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            word_valid <= 1'b0;
        end else if (desc_ready) begin
            word_valid <= desc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (desc_valid && desc_ready) begin
            word <= enc;
        end
    end

endmodule

`default_nettype wire

/* display_init_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module display_init_seq
    import disp_pkg::*;
#(
    parameter int GAP_UNIT = 3
) (
    input  logic      clk,
    input  logic      nrst,
    output bus_word_t word,
    output logic      word_valid,
    input  logic      word_ready,
    output logic      done
);

    logic [IDX_W-1:0] rd_idx;
    script_entry_t    rd_entry;
    word_desc_t       desc;
    logic             desc_valid;
    logic             desc_ready;
    logic             word_taken;

    // Gap counting starts at the output handshake
    assign word_taken = word_valid && word_ready;

    script_rom u_script_rom (
        .clk      (clk),
        .nrst     (nrst),
        .rd_idx   (rd_idx),
        .rd_entry (rd_entry)
    );

    step_sequencer #(
        .GAP_UNIT (GAP_UNIT)
    ) u_step_sequencer (
        .clk        (clk),
        .nrst       (nrst),
        .rd_idx     (rd_idx),
        .rd_entry   (rd_entry),
        .desc       (desc),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .word_taken (word_taken),
        .done       (done)
    );

    bus_out_stage u_bus_out_stage (
        .clk        (clk),
        .nrst       (nrst),
        .desc       (desc),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready)
    );

endmodule

`default_nettype wire

/* tb_expected.svh */
`ifndef TB_EXPECTED_SVH
`define TB_EXPECTED_SVH

typedef struct packed {
    logic [15:0] word;
    int          gap;
} exp_word_t;

localparam int ENTRIES = 40;

// Row layout {upper byte, value, gap, pairs}
// Upper byte 40 marks a poll run
function automatic logic [31:0] script_row(input int e);
    case (e)
        0:  script_row = 32'h40_00_01_01;
        1:  script_row = 32'h80_88_01_00;
        2:  script_row = 32'h00_0B_2B_00;
        3:  script_row = 32'h80_89_01_00;
        4:  script_row = 32'h00_02_2B_00;
        5:  script_row = 32'h80_10_01_00;
        6:  script_row = 32'h00_0C_01_00;
        7:  script_row = 32'h80_04_01_00;
        8:  script_row = 32'h00_81_2B_00;
        9:  script_row = 32'h80_14_01_00;
        10: script_row = 32'h00_63_01_00;
        11: script_row = 32'h80_19_01_00;
        12: script_row = 32'h00_DF_04_00;
        13: script_row = 32'h80_36_01_00;
        14: script_row = 32'h00_DF_01_00;
        15: script_row = 32'h80_8A_01_00;
        16: script_row = 32'h00_8A_01_00;
        17: script_row = 32'h80_90_01_00;
        18: script_row = 32'h00_B0_01_00;
        19: script_row = 32'h40_90_01_3C;
        20: script_row = 32'h40_40_01_01;
        21: script_row = 32'h80_99_01_00;
        22: script_row = 32'h00_90_01_00;
        23: script_row = 32'h80_9A_01_00;
        24: script_row = 32'h00_01_01_00;
        25: script_row = 32'h80_9B_01_00;
        26: script_row = 32'h00_F0_01_00;
        27: script_row = 32'h80_9C_01_00;
        28: script_row = 32'h00_00_01_00;
        29: script_row = 32'h80_9D_01_00;
        30: script_row = 32'h00_32_01_00;
        31: script_row = 32'h80_63_01_00;
        32: script_row = 32'h00_1F_01_00;
        33: script_row = 32'h80_64_01_00;
        34: script_row = 32'h00_00_01_00;
        35: script_row = 32'h80_65_01_00;
        36: script_row = 32'h00_1F_01_00;
        37: script_row = 32'h80_90_01_00;
        38: script_row = 32'h00_60_01_00;
        39: script_row = 32'h40_90_01_3C;
        default: script_row = 32'h0;
    endcase
endfunction

function automatic int words_in_row(input logic [31:0] row);
    int cnt;
    cnt = row[7:0];
    if (row[31:24] == 8'h40) begin
        words_in_row = 2 * cnt;
    end else begin
        words_in_row = 1;
    end
endfunction

function automatic int total_words();
    int sum;
    sum = 0;
    for (int e = 0; e < ENTRIES; e++) begin
        sum = sum + words_in_row(script_row(e));
    end
    return sum;
endfunction

function automatic int max_gap();
    int g;
    logic [31:0] row;
    g = 0;
    for (int e = 0; e < ENTRIES; e++) begin
        row = script_row(e);
        if (row[15:8] > g) begin
            g = row[15:8];
        end
    end
    return g;
endfunction

// Poll runs expand into select 80xx then read 4000, pair after pair
function automatic exp_word_t ref_word(input int n);
    exp_word_t res;
    logic [31:0] row;
    int left;
    logic found;
    res = '0;
    left = n;
    found = 1'b0;
    for (int e = 0; e < ENTRIES; e++) begin
        row = script_row(e);
        if (!found && left < words_in_row(row)) begin
            found = 1'b1;
            res.gap = row[15:8];
            if (row[31:24] != 8'h40) begin
                res.word = {row[31:24], row[23:16]};
            end else if (left % 2 == 0) begin
                res.word = {8'h80, row[23:16]};
            end else begin
                res.word = 16'h4000;
            end
        end else if (!found) begin
            left = left - words_in_row(row);
        end
    end
    return res;
endfunction

`endif

/* tb_display_init_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_display_init_seq
    import disp_pkg::*;
();

    localparam int GAP_UNIT = 3;

    `include "tb_expected.svh"

    logic        clk;
    logic        nrst;
    logic        word_ready;
    bus_word_t   word;
    logic        word_valid;
    logic        done;

    int          seed;
    int          n_acc;
    int          cycle;
    int          last_accept;
    int          last_gap;
    int          expected_total;
    logic        stalled;
    logic [15:0] held;
    logic        prev_valid;
    exp_word_t   exp_w;

    display_init_seq #(
        .GAP_UNIT (GAP_UNIT)
    ) u_display_init_seq (
        .clk        (clk),
        .nrst       (nrst),
        .word       (word),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .done       (done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Ready is high about three cycles in four
    always @(posedge clk) begin
        if (nrst) begin
            word_ready <= #1 (($random(seed) & 3) != 0);
        end
    end

    always @(posedge clk) begin
        if (nrst) begin
            cycle = cycle + 1;
            if (stalled) begin
                compare_value("word_valid while stalled", 1, word_valid);
                compare_value("word while stalled", held, word);
            end
            // Rise seen now happened one edge earlier
            if (word_valid && !prev_valid && n_acc > 0) begin
                compare_value("gap cycles >= gap x GAP_UNIT", 1,
                              (cycle - 1 - last_accept) >= last_gap * GAP_UNIT);
            end
            if (n_acc < expected_total) begin
                compare_value("done before last word", 0, done);
            end
            if (word_valid && word_ready) begin
                if (n_acc >= expected_total) begin
                    $display("Extra word %0h accepted after the end of the script", word);
                    $display("=== FAIL ===");
                    $fatal(1, "Extra word");
                end
                exp_w = ref_word(n_acc);
                compare_value("word", exp_w.word, word);
                last_accept = cycle;
                last_gap = exp_w.gap;
                n_acc = n_acc + 1;
            end
            stalled = word_valid && !word_ready;
            held = word;
            prev_valid = word_valid;
        end
    end

    initial begin
        seed = 72504;
        nrst = 1'b0;
        word_ready = 1'b0;
        n_acc = 0;
        cycle = 0;
        last_accept = 0;
        last_gap = 0;
        stalled = 1'b0;
        held = '0;
        prev_valid = 1'b0;
        expected_total = total_words();
        repeat (8) begin
            @(posedge clk);
            #1;
            compare_value("word_valid in reset", 0, word_valid);
            compare_value("done in reset", 0, done);
        end
        nrst = 1'b1;
        @(posedge clk);
        #1;
        compare_value("word_valid after reset", 0, word_valid);
        compare_value("done after reset", 0, done);
        while (!done) begin
            @(posedge clk);
            #1;
        end
        compare_value("accepted word count", expected_total, n_acc);
        repeat (50) begin
            @(posedge clk);
            #1;
            compare_value("word_valid after done", 0, word_valid);
            compare_value("done held", 1, done);
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        int limit;
        limit = total_words() * (max_gap() * GAP_UNIT + 20) + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: the script did not finish within %0d cycles", limit);
        $display("=== FAIL ===");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
disp_pkg.sv
script_rom.sv
step_sequencer.sv
bus_out_stage.sv
display_init_seq.sv
tb_display_init_seq.sv
